//--- Bender.yml
package:
  name: music_player

export_include_dirs:
  - logic

sources:
  - logic/music_pkg.sv
  - logic/beat_timer.sv
  - logic/song_rom.sv
  - logic/song_reader.sv
  - logic/note_player.sv
  - logic/music_player_top.sv
  - target: test
    files:
      - test/music_player_assertions.sv
      - test/music_player_tb.sv

//--- logic/beat_timer.sv
`timescale 1ns/100ps
`include "music_params.svh"

module beat_timer #(
    parameter int beat_period = `BEAT_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    output logic beat
);

    localparam int cnt_width = (beat_period > 1) ? $clog2(beat_period) : 1;
    localparam logic [cnt_width-1:0] last_count = cnt_width'(beat_period - 1);

    logic [cnt_width-1:0] cnt;

    // free running, wraps at beat_period - 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == last_count) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // registered strobe, so the first beat lands beat_period cycles after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= 1'b0;
        end else begin
            beat <= (cnt == last_count);
        end
    end

endmodule

//--- logic/music_params.svh
`ifndef MUSIC_PARAMS_SVH
`define MUSIC_PARAMS_SVH

// --------------------
// field widths
// --------------------
`define SONG_WIDTH      2
`define NOTE_WIDTH      6
`define DURATION_WIDTH  6
`define TIMBRE_WIDTH    3

// 32 notes per song
`define NOTES_PER_SONG_LOG 5

// rom geometry, song number on top of the note number
`define ROM_ADDR_WIDTH  (`SONG_WIDTH + `NOTES_PER_SONG_LOG)
`define ROM_WORD_WIDTH  16

// --------------------
// timing
// --------------------
// clock cycles per beat
`define BEAT_CYCLES 1000

`endif

//--- logic/music_pkg.sv
`include "music_params.svh"

package music_pkg;

    typedef logic [`SONG_WIDTH-1:0]     song_sel_t;
    // note 0 is silence
    typedef logic [`NOTE_WIDTH-1:0]     note_t;
    // length in beats
    typedef logic [`DURATION_WIDTH-1:0] duration_t;
    // voice select
    typedef logic [`TIMBRE_WIDTH-1:0]   timbre_t;

    // rom word layout
    //   [15]    sounding flag
    //   [14:9]  note
    //   [8:3]   duration
    //   [2:0]   timbre

    // reader fsm states
    typedef enum logic [2:0] {
        paused            = 3'b000,
        wait_note         = 3'b001,
        increment_address = 3'b010,
        retrieve_note     = 3'b011,
        new_note_ready    = 3'b100
    } reader_state_t;

endpackage

//--- logic/music_player_top.sv
`timescale 1ns/100ps
`include "music_params.svh"

module music_player_top #(
    parameter int beat_period = `BEAT_CYCLES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 play,
    input  music_pkg::song_sel_t song,
    output music_pkg::note_t     note,
    output music_pkg::duration_t duration,
    output music_pkg::timbre_t   timbre,
    output logic                 sounding,
    output logic                 new_note,
    output logic                 song_done
);

    logic beat;
    logic note_done;
    logic [`ROM_ADDR_WIDTH-1:0] rom_addr;
    logic [`ROM_WORD_WIDTH-1:0] rom_word;

    beat_timer #(
        .beat_period(beat_period)
    ) u_timer (
        .clk  (clk),
        .rst_n(rst_n),
        .beat (beat)
    );

    song_reader u_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .play     (play),
        .song     (song),
        .note_done(note_done),
        .rom_word (rom_word),
        .rom_addr (rom_addr),
        .new_note (new_note),
        .song_done(song_done),
        .sounding (sounding),
        .note     (note),
        .duration (duration),
        .timbre   (timbre)
    );

    song_rom u_rom (
        .clk (clk),
        .addr(rom_addr),
        .dout(rom_word)
    );

    note_player u_player (
        .clk      (clk),
        .rst_n    (rst_n),
        .new_note (new_note),
        .play     (play),
        .beat     (beat),
        .duration (duration),
        .note_done(note_done)
    );

endmodule

//--- logic/note_player.sv
`timescale 1ns/100ps

module note_player (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 new_note,
    input  logic                 play,
    input  logic                 beat,
    input  music_pkg::duration_t duration,
    output logic                 note_done
);
    import music_pkg::*;

    duration_t beats_left;
    logic loaded;

    // beat countdown, frozen while play is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beats_left <= '0;
        end else if (new_note) begin
            beats_left <= duration;
        end else if (beat && play && (beats_left != '0)) begin
            beats_left <= beats_left - duration_t'(1);
        end
    end

    // --------------------
    // end of note
    // --------------------
    // loaded is armed by new_note and cleared once note_done has fired
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded    <= 1'b0;
            note_done <= 1'b0;
        end else begin
            note_done <= 1'b0;
            if (new_note) begin
                loaded <= 1'b1;
            end else if (loaded && (beats_left == '0)) begin
                loaded    <= 1'b0;
                note_done <= 1'b1;
            end
        end
    end

endmodule

//--- logic/song_reader.sv
`timescale 1ns/100ps
`include "music_params.svh"

module song_reader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       play,
    input  music_pkg::song_sel_t       song,
    input  logic                       note_done,
    input  logic [`ROM_WORD_WIDTH-1:0] rom_word,
    output logic [`ROM_ADDR_WIDTH-1:0] rom_addr,
    output logic                       new_note,
    output logic                       song_done,
    output logic                       sounding,
    output music_pkg::note_t           note,
    output music_pkg::duration_t       duration,
    output music_pkg::timbre_t         timbre
);
    import music_pkg::*;

    reader_state_t state;
    reader_state_t next_state;
    logic [`NOTES_PER_SONG_LOG-1:0] note_num;
    logic [`NOTES_PER_SONG_LOG-1:0] next_note_num;
    logic carry;
    logic advance;
    logic finished;
    logic [`ROM_WORD_WIDTH-1:0] held_word;
    logic [`ROM_WORD_WIDTH-1:0] cur_word;

    // --------------------
    // note counter
    // --------------------
    // only step on with play high, a pause here replays the note
    assign advance = (state == increment_address) && play;
    assign {carry, next_note_num} = {1'b0, note_num} + {{`NOTES_PER_SONG_LOG{1'b0}}, 1'b1};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note_num <= '0;
        end else if (advance) begin
            note_num <= next_note_num;
        end
    end

    assign rom_addr  = {song, note_num};
    assign song_done = advance && carry;

    // song over, wait for play to be released before starting again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finished <= 1'b0;
        end else if (!play) begin
            finished <= 1'b0;
        end else if (song_done) begin
            finished <= 1'b1;
        end
    end

    // --------------------
    // fsm
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= paused;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (!play) begin
            next_state = paused;
        end else begin
            case (state)
                paused:            if (!finished) next_state = retrieve_note;
                retrieve_note:     next_state = new_note_ready;
                new_note_ready:    next_state = wait_note;
                wait_note:         if (note_done) next_state = increment_address;
                increment_address: next_state = carry ? paused : retrieve_note;
                default:           next_state = paused;
            endcase
        end
    end

    assign new_note = (state == new_note_ready);

    // --------------------
    // note fields
    // --------------------
    // rom word is valid in new_note_ready, keep it until the next note
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_word <= '0;
        end else if (new_note) begin
            held_word <= rom_word;
        end
    end

    assign cur_word = new_note ? rom_word : held_word;

    assign sounding = cur_word[15];
    assign note     = cur_word[14:9];
    assign duration = cur_word[8:3];
    assign timbre   = cur_word[2:0];

endmodule

//--- logic/song_rom.sv
`timescale 1ns/100ps
`include "music_params.svh"

module song_rom (
    input  logic                       clk,
    input  logic [`ROM_ADDR_WIDTH-1:0] addr,
    output logic [`ROM_WORD_WIDTH-1:0] dout
);
    import music_pkg::*;

    song_sel_t song;
    logic [`NOTES_PER_SONG_LOG-1:0] idx;
    logic [`NOTE_WIDTH+`DURATION_WIDTH-1:0] entry;
    note_t base_note;
    duration_t dur;
    note_t note;
    logic [`ROM_WORD_WIDTH-1:0] word;

    assign song = addr[`ROM_ADDR_WIDTH-1:`NOTES_PER_SONG_LOG];
    assign idx  = addr[`NOTES_PER_SONG_LOG-1:0];

    // --------------------
    // shared melody, {note, beats}
    // --------------------
    always_comb begin
        case (idx)
            5'd0:    entry = {6'd20, 6'd2};
            5'd1:    entry = {6'd22, 6'd2};
            5'd2:    entry = {6'd24, 6'd4};
            5'd3:    entry = {6'd20, 6'd2};
            5'd4:    entry = {6'd25, 6'd2};
            5'd5:    entry = {6'd27, 6'd4};
            5'd6:    entry = {6'd0,  6'd1};
            5'd7:    entry = {6'd27, 6'd2};
            5'd8:    entry = {6'd29, 6'd2};
            5'd9:    entry = {6'd27, 6'd2};
            5'd10:   entry = {6'd25, 6'd2};
            5'd11:   entry = {6'd24, 6'd4};
            5'd12:   entry = {6'd22, 6'd2};
            5'd13:   entry = {6'd24, 6'd2};
            5'd14:   entry = {6'd20, 6'd8};
            5'd15:   entry = {6'd0,  6'd2};
            5'd16:   entry = {6'd32, 6'd1};
            5'd17:   entry = {6'd31, 6'd1};
            5'd18:   entry = {6'd29, 6'd2};
            5'd19:   entry = {6'd27, 6'd2};
            5'd20:   entry = {6'd29, 6'd4};
            5'd21:   entry = {6'd25, 6'd2};
            5'd22:   entry = {6'd24, 6'd2};
            5'd23:   entry = {6'd22, 6'd4};
            5'd24:   entry = {6'd20, 6'd3};
            5'd25:   entry = {6'd22, 6'd1};
            5'd26:   entry = {6'd24, 6'd2};
            5'd27:   entry = {6'd25, 6'd2};
            5'd28:   entry = {6'd24, 6'd3};
            5'd29:   entry = {6'd22, 6'd1};
            5'd30:   entry = {6'd20, 6'd6};
            default: entry = {6'd0,  6'd4};
        endcase
    end

    assign base_note = entry[`NOTE_WIDTH+`DURATION_WIDTH-1:`DURATION_WIDTH];
    assign dur       = entry[`DURATION_WIDTH-1:0];

    // each song is the melody transposed up by 3 steps per song number
    // rests stay at 0
    assign note = (base_note == '0) ? '0 : base_note + note_t'(song) * note_t'(3);

    // sounding, note, duration, timbre
    assign word = {(base_note != '0), note, dur, timbre_t'(song)};

    always_ff @(posedge clk) begin
        dout <= word;
    end

endmodule

//--- sources.f
+incdir+logic
logic/music_pkg.sv
logic/beat_timer.sv
logic/song_rom.sv
logic/song_reader.sv
logic/note_player.sv
logic/music_player_top.sv
test/music_player_assertions.sv
test/music_player_tb.sv

//--- test/music_player_assertions.sv
`timescale 1ns/100ps

module music_player_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       play,
    input logic                       beat,
    input logic                       note_done,
    input logic                       new_note,
    input logic                       song_done,
    input logic                       sounding,
    input music_pkg::note_t           note,
    input music_pkg::duration_t       duration,
    input music_pkg::timbre_t         timbre,
    input music_pkg::reader_state_t   state
);
    import music_pkg::*;

    // counted by the action blocks, polled by the testbench
    int error_count = 0;

    // --------------------
    // one-cycle strobes
    // --------------------
    a_new_note_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        new_note |=> !new_note)
        else begin
            error_count++;
            $error("CHECK FAILED new_note_pulse: expected 0, actual 1");
        end

    a_note_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        note_done |=> !note_done)
        else begin
            error_count++;
            $error("CHECK FAILED note_done_pulse: expected 0, actual 1");
        end

    a_beat_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        beat |=> !beat)
        else begin
            error_count++;
            $error("CHECK FAILED beat_pulse: expected 0, actual 1");
        end

    // --------------------
    // reader timing
    // --------------------
    // next note three cycles after note_done
    a_done_to_next: assert property (@(posedge clk) disable iff (!rst_n)
        (note_done && play && state == wait_note) ##1 (play && !song_done) ##1 play
        |=> new_note)
        else begin
            error_count++;
            $error("CHECK FAILED done_to_next: expected new_note 3 cycles after note_done");
        end

    a_start_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (state == paused && $rose(play)) ##1 play |=> new_note)
        else begin
            error_count++;
            $error("CHECK FAILED start_latency: expected new_note 2 cycles after play");
        end

    a_song_done_pause: assert property (@(posedge clk) disable iff (!rst_n)
        song_done |=> state == paused)
        else begin
            error_count++;
            $error("CHECK FAILED song_done_pause: expected paused, actual %s", state.name());
        end

    a_quiet_when_paused: assert property (@(posedge clk) disable iff (!rst_n)
        !play |=> !new_note)
        else begin
            error_count++;
            $error("CHECK FAILED quiet_when_paused: new_note while play was low");
        end

    // held fields only move with new_note
    a_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !new_note |-> $stable({sounding, note, duration, timbre}))
        else begin
            error_count++;
            $error("CHECK FAILED fields_stable: expected %h, actual %h",
                $past({sounding, note, duration, timbre}), {sounding, note, duration, timbre});
        end

endmodule

bind music_player_top music_player_assertions u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .play     (play),
    .beat     (beat),
    .note_done(note_done),
    .new_note (new_note),
    .song_done(song_done),
    .sounding (sounding),
    .note     (note),
    .duration (duration),
    .timbre   (timbre),
    .state    (u_reader.state)
);

//--- test/music_player_tb.sv
`timescale 1ns/100ps
`include "music_params.svh"

module music_player_tb;
    import music_pkg::*;

    localparam int beat_period    = 4;
    localparam int notes_per_song = 1 << `NOTES_PER_SONG_LOG;
    // longest note is 8 beats
    localparam int note_timeout   = 20 * beat_period * 8;

    logic      clk;
    logic      rst_n;
    logic      play;
    song_sel_t song;
    note_t     note;
    duration_t duration;
    timbre_t   timbre;
    logic      sounding;
    logic      new_note;
    logic      song_done;

    int        seed = 94;
    note_t     played [3][notes_per_song];
    int        beat_cnt;
    duration_t cur_dur;
    logic      counting;

    music_player_top #(
        .beat_period(beat_period)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .play     (play),
        .song     (song),
        .note     (note),
        .duration (duration),
        .timbre   (timbre),
        .sounding (sounding),
        .new_note (new_note),
        .song_done(song_done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                name, expected, actual));
        end
    endtask

    // stop at the first assertion error
    always @(posedge clk) begin
        if (DUT.u_assert.error_count != 0) begin
            report_failure("a concurrent assertion in the DUT failed");
        end
    end

    // --------------------
    // beat count per note
    // --------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            counting <= 1'b0;
            beat_cnt <= 0;
        end else if (new_note) begin
            if (duration == '0 || duration > 6'd8) begin
                report_failure($sformatf(
                    "CHECK FAILED note_duration: expected 1 to 8, actual %0d", duration));
            end
            cur_dur  <= duration;
            beat_cnt <= 0;
            counting <= 1'b1;
        end else if (DUT.note_done && counting) begin
            check_value("beats_per_note", cur_dur, beat_cnt);
            counting <= 1'b0;
        end else if (DUT.beat && play && counting) begin
            beat_cnt <= beat_cnt + 1;
        end
    end

    task automatic wait_for_new_note(input string what, output int cycles);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            n++;
            if (new_note) begin
                seen = 1'b1;
            end else if (song_done) begin
                report_failure($sformatf("CHECK FAILED %s: expected new_note, actual song_done",
                    what));
            end else if (n >= note_timeout) begin
                report_failure($sformatf("timeout while waiting for new_note in %s", what));
            end
        end
        cycles = n;
    endtask

    task automatic wait_for_song_done(input string what);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            n++;
            if (song_done) begin
                seen = 1'b1;
            end else if (new_note) begin
                report_failure($sformatf("CHECK FAILED %s: expected song_done, actual new_note",
                    what));
            end else if (n >= note_timeout) begin
                report_failure($sformatf("timeout while waiting for song_done in %s", what));
            end
        end
    endtask

    // plays one song, pausing right after some of its notes
    task automatic run_song(input int run, input song_sel_t sel, input logic from_reset);
        int lat;
        int hold;
        int extra;
        if (!from_reset) begin
            @(negedge clk);
            play = 1'b0;
            repeat (2) @(negedge clk);
            song = sel;
            play = 1'b1;
        end
        for (int k = 0; k < notes_per_song; k++) begin
            wait_for_new_note("next_note", lat);
            if (k == 0 && from_reset) begin
                check_value("start_after_reset", 3, lat);
            end else if (k == 0) begin
                // first edge samples play
                check_value("start_after_play", 2, lat - 1);
            end
            played[run][k] = note;
            if (($random(seed) & 7) == 0) begin
                @(negedge clk);
                play = 1'b0;
                hold = 1 + ($unsigned($random(seed)) % 8);
                repeat (hold) @(negedge clk);
                play = 1'b1;
                wait_for_new_note("resume", lat);
                check_value("resume_note", played[run][k], note);
            end
        end
        wait_for_song_done("song_end");
        // play stays high, reader must stay paused
        extra = 0;
        repeat (4 * beat_period) begin
            @(posedge clk);
            if (new_note) begin
                extra++;
            end
        end
        check_value("paused_after_song", 0, extra);
    endtask

    initial begin
        int diff_pos;
        song_sel_t third;
        rst_n = 1'b0;
        play  = 1'b1;
        song  = 2'd0;
        repeat (10) @(negedge clk);
        check_value("reset_new_note", 0, new_note);
        check_value("reset_song_done", 0, song_done);
        check_value("reset_sounding", 0, sounding);
        rst_n = 1'b1;

        run_song(0, 2'd0, 1'b1);
        run_song(1, 2'd2, 1'b0);

        // song 2 reads a different table
        diff_pos = -1;
        for (int k = 0; k < notes_per_song; k++) begin
            if (diff_pos < 0 && played[1][k] != played[0][k]) begin
                diff_pos = k;
            end
        end
        if (diff_pos < 0) begin
            report_failure("CHECK FAILED song_select: expected differing notes, actual equal");
        end

        third = song_sel_t'($unsigned($random(seed)) % 4);
        run_song(2, third, 1'b0);

        if (DUT.u_assert.error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            report_failure("concurrent assertion errors were raised");
        end
    end

endmodule
